// ==== hw/debug_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module debug_ctrl #(
    parameter int IMEM_DEPTH   = 64,
    parameter int DRAIN_CYCLES = 3
) (
    input  wire                                  i_clk,
    input  wire                                  i_reset,
    input  wire  debug_pkg::word_xfer_t          i_word,
    input  wire                                  i_word_req,
    output logic                                 o_word_ack,
    input  wire                                  i_program_end,
    output logic                                 o_halt,
    output logic                                 o_stall,
    output logic                                 o_pc_reset,
    output logic                                 o_imem_we,
    output logic [$clog2(IMEM_DEPTH)+1:0]        o_imem_addr,
    output logic [31:0]                          o_imem_data,
    output logic                                 o_dump_req,
    input  wire                                  i_dump_ack
);

    localparam int DC_W = $clog2(DRAIN_CYCLES + 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_CHARGE,
        S_RUN,
        S_DRAIN,
        S_STEP,
        S_STEP_EXEC,
        S_DUMP,
        S_DUMP_END
    } state_t;

    state_t          state;
    logic            prog_loaded;
    logic            step_mode;
    logic [DC_W-1:0] drain_cnt;
    logic            drain_stall;
    logic            accepting;
    logic            accept;
    logic [31:0]     word;

    assign word      = i_word.data;
    assign accepting = (state == S_IDLE) || (state == S_CHARGE) || (state == S_STEP);
    assign accept    = accepting && i_word_req && !o_word_ack;

    // stall during drain, and in the single step cycle if the end marker is in decode
    assign o_stall = drain_stall || ((state == S_STEP_EXEC) && i_program_end);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state       <= S_IDLE;
            prog_loaded <= 1'b0;
            step_mode   <= 1'b0;
            drain_cnt   <= '0;
            drain_stall <= 1'b0;
            o_word_ack  <= 1'b0;
            o_halt      <= 1'b1;
            o_pc_reset  <= 1'b0;
            o_imem_we   <= 1'b0;
            o_imem_addr <= '0;
            o_dump_req  <= 1'b0;
        end else begin
            o_pc_reset <= 1'b0;
            o_imem_we  <= 1'b0;

            if (o_word_ack && !i_word_req) begin
                o_word_ack <= 1'b0;
            end else if (accept) begin
                o_word_ack <= 1'b1;
            end

            // advance the write address once the word is in
            if (o_imem_we) begin
                o_imem_addr <= (o_imem_data == debug_pkg::end_instr) ? '0 : o_imem_addr + 4;
            end

            case (state)
                S_IDLE: begin
                    if (accept) begin
                        if (word == debug_pkg::cmd_charge) begin
                            prog_loaded <= 1'b0;  // memory is being rewritten
                            state       <= S_CHARGE;
                        end else if (word == debug_pkg::cmd_cont && prog_loaded) begin
                            o_halt <= 1'b0;
                            state  <= S_RUN;
                        end else if (word == debug_pkg::cmd_step && prog_loaded) begin
                            step_mode <= 1'b1;
                            state     <= S_STEP;
                        end
                    end
                end

                S_CHARGE: begin
                    if (accept) begin
                        o_imem_we <= 1'b1;
                        if (word == debug_pkg::end_instr) begin
                            prog_loaded <= 1'b1;
                            o_pc_reset  <= 1'b1;
                            state       <= S_IDLE;
                        end
                    end
                end

                S_RUN: begin
                    if (i_program_end) begin
                        drain_stall <= 1'b1;  // let the last real instruction leave
                        drain_cnt   <= '0;
                        state       <= S_DRAIN;
                    end
                end

                S_DRAIN: begin
                    drain_cnt <= drain_cnt + 1'b1;
                    if (drain_cnt == DC_W'(DRAIN_CYCLES - 1)) begin
                        drain_stall <= 1'b0;
                        o_halt      <= 1'b1;
                        o_dump_req  <= 1'b1;
                        state       <= S_DUMP;
                    end
                end

                S_STEP: begin
                    if (accept) begin
                        if (word == debug_pkg::cmd_next) begin
                            o_halt <= 1'b0;   // exactly one clock of execution
                            state  <= S_STEP_EXEC;
                        end else if (word == debug_pkg::cmd_cancel) begin
                            step_mode  <= 1'b0;
                            o_pc_reset <= 1'b1;
                            state      <= S_IDLE;
                        end
                    end
                end

                S_STEP_EXEC: begin
                    o_halt     <= 1'b1;
                    o_dump_req <= 1'b1;
                    state      <= S_DUMP;
                end

                S_DUMP: begin
                    if (i_dump_ack) begin
                        o_dump_req <= 1'b0;
                        state      <= S_DUMP_END;
                    end
                end

                S_DUMP_END: begin
                    if (!i_dump_ack) begin
                        if (step_mode) begin
                            state <= S_STEP;
                        end else begin
                            o_pc_reset <= 1'b1;  // continuous run is over
                            state      <= S_IDLE;
                        end
                    end
                end

                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept && state == S_CHARGE) begin
            o_imem_data <= word;
        end
    end

endmodule

`default_nettype wire

// ==== hw/debug_pkg.sv ====
`default_nettype none

package debug_pkg;

    // mode selection words, sent as four ascii bytes
    localparam logic [31:0] cmd_charge = "\0chm";
    localparam logic [31:0] cmd_cont   = "\0com";
    localparam logic [31:0] cmd_step   = "\0stm";

    // step mode control words
    localparam logic [31:0] cmd_next   = "nxst";
    localparam logic [31:0] cmd_cancel = "clst";

    // end of program marker, stored in memory like any instruction
    localparam logic [31:0] end_instr  = 32'hffff_ffff;

    // one word from the uart word assembler to the controller
    typedef struct packed {
        logic [31:0] data;
    } word_xfer_t;

    // the four pipeline latches, if_id goes out first
    typedef struct packed {
        logic [63:0]  if_id;
        logic [138:0] id_ex;
        logic [75:0]  ex_mem;
        logic [70:0]  mem_wb;
        logic [1:0]   pad;    // always zero, rounds up to whole bytes
    } pipe_snapshot_t;

    localparam int snap_bytes = $bits(pipe_snapshot_t) / 8;    // 44

endpackage

`default_nettype wire

// ==== hw/debug_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module debug_top #(
    parameter int IMEM_DEPTH   = 64,
    parameter int DRAIN_CYCLES = 3
) (
    input  wire                             i_clk,
    input  wire                             i_reset,
    input  wire                             i_rx_valid,
    input  wire  [7:0]                      i_rx_byte,
    output logic                            o_tx_req,
    output logic [7:0]                      o_tx_byte,
    input  wire                             i_tx_ack,
    input  wire                             i_program_end,
    input  wire  [$clog2(IMEM_DEPTH)+1:0]   i_fetch_addr,
    input  wire  debug_pkg::pipe_snapshot_t i_snapshot,
    output logic [31:0]                     o_fetch_instr,
    output logic                            o_halt,
    output logic                            o_stall,
    output logic                            o_pc_reset
);

    localparam int AW = $clog2(IMEM_DEPTH) + 2;

    debug_pkg::word_xfer_t word;
    logic                  word_req;
    logic                  word_ack;
    logic                  imem_we;
    logic [AW-1:0]         imem_addr;
    logic [31:0]           imem_data;
    logic                  dump_req;
    logic                  dump_ack;

    uart_word_rx u_word_rx (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_rx_valid (i_rx_valid),
        .i_rx_byte  (i_rx_byte),
        .o_word     (word),
        .o_word_req (word_req),
        .i_word_ack (word_ack)
    );

    debug_ctrl #(
        .IMEM_DEPTH   (IMEM_DEPTH),
        .DRAIN_CYCLES (DRAIN_CYCLES)
    ) u_ctrl (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_word        (word),
        .i_word_req    (word_req),
        .o_word_ack    (word_ack),
        .i_program_end (i_program_end),
        .o_halt        (o_halt),
        .o_stall       (o_stall),
        .o_pc_reset    (o_pc_reset),
        .o_imem_we     (imem_we),
        .o_imem_addr   (imem_addr),
        .o_imem_data   (imem_data),
        .o_dump_req    (dump_req),
        .i_dump_ack    (dump_ack)
    );

    instr_mem #(
        .IMEM_DEPTH (IMEM_DEPTH)
    ) u_imem (
        .i_clk         (i_clk),
        .i_we          (imem_we),
        .i_waddr       (imem_addr),
        .i_wdata       (imem_data),
        .i_fetch_addr  (i_fetch_addr),
        .o_fetch_instr (o_fetch_instr)
    );

    latch_dump u_dump (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_snapshot (i_snapshot),
        .i_dump_req (dump_req),
        .o_dump_ack (dump_ack),
        .o_tx_req   (o_tx_req),
        .o_tx_byte  (o_tx_byte),
        .i_tx_ack   (i_tx_ack)
    );

endmodule

`default_nettype wire

// ==== hw/instr_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_mem #(
    parameter int IMEM_DEPTH = 64
) (
    input  wire                            i_clk,
    input  wire                            i_we,
    input  wire  [$clog2(IMEM_DEPTH)+1:0]  i_waddr,
    input  wire  [31:0]                    i_wdata,
    input  wire  [$clog2(IMEM_DEPTH)+1:0]  i_fetch_addr,
    output logic [31:0]                    o_fetch_instr
);

    localparam int AW = $clog2(IMEM_DEPTH) + 2;

    logic [31:0] mem [IMEM_DEPTH];

    // byte addresses in, word index is addr / 4
    always_ff @(posedge i_clk) begin
        if (i_we) begin
            mem[i_waddr[AW-1:2]] <= i_wdata;
        end
    end

    always_ff @(posedge i_clk) begin
        o_fetch_instr <= mem[i_fetch_addr[AW-1:2]];  // one cycle read latency
    end

endmodule

`default_nettype wire

// ==== hw/latch_dump.sv ====
`timescale 1ns/1ps
`default_nettype none

module latch_dump (
    input  wire                             i_clk,
    input  wire                             i_reset,
    input  wire  debug_pkg::pipe_snapshot_t i_snapshot,
    input  wire                             i_dump_req,
    output logic                            o_dump_ack,
    output logic                            o_tx_req,
    output logic [7:0]                      o_tx_byte,
    input  wire                             i_tx_ack
);

    localparam int SW = $bits(debug_pkg::pipe_snapshot_t);
    localparam int CW = $clog2(debug_pkg::snap_bytes);

    typedef enum logic [1:0] {
        D_IDLE,
        D_REQ,
        D_ACK_LOW,
        D_DONE
    } dstate_t;

    dstate_t       state;
    logic [SW-1:0] shift_q;
    logic [CW-1:0] byte_cnt;
    logic          last_byte;

    assign last_byte = (byte_cnt == CW'(debug_pkg::snap_bytes - 1));
    assign o_tx_byte = shift_q[SW-1 -: 8];  // top byte is the one on offer

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state      <= D_IDLE;
            byte_cnt   <= '0;
            o_tx_req   <= 1'b0;
            o_dump_ack <= 1'b0;
        end else begin
            case (state)
                D_IDLE: begin
                    if (i_dump_req) begin
                        byte_cnt <= '0;
                        o_tx_req <= 1'b1;
                        state    <= D_REQ;
                    end
                end

                D_REQ: begin
                    if (i_tx_ack) begin
                        o_tx_req <= 1'b0;
                        state    <= D_ACK_LOW;
                    end
                end

                D_ACK_LOW: begin
                    if (!i_tx_ack) begin
                        if (last_byte) begin
                            o_dump_ack <= 1'b1;
                            state      <= D_DONE;
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                            o_tx_req <= 1'b1;
                            state    <= D_REQ;
                        end
                    end
                end

                D_DONE: begin
                    if (!i_dump_req) begin
                        o_dump_ack <= 1'b0;
                        state      <= D_IDLE;
                    end
                end

                default: state <= D_IDLE;
            endcase
        end
    end

    // snapshot is frozen at accept, then shifted a byte per completed transfer
    always_ff @(posedge i_clk) begin
        if (state == D_IDLE && i_dump_req) begin
            shift_q <= i_snapshot;
        end else if (state == D_ACK_LOW && !i_tx_ack && !last_byte) begin
            shift_q <= {shift_q[SW-9:0], 8'h00};
        end
    end

endmodule

`default_nettype wire

// ==== hw/uart_word_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_word_rx (
    input  wire                       i_clk,
    input  wire                       i_reset,
    input  wire                       i_rx_valid,
    input  wire  [7:0]                i_rx_byte,
    output debug_pkg::word_xfer_t     o_word,
    output logic                      o_word_req,
    input  wire                       i_word_ack
);

    logic [31:0] word_q;      // assembled word, msb first
    logic [1:0]  byte_cnt;
    logic        wait_ack_low; // req dropped, waiting for the controller to release ack
    logic        take_byte;

    // a byte is only taken while no word is pending
    assign take_byte = i_rx_valid && !o_word_req && !wait_ack_low;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            byte_cnt     <= 2'd0;
            o_word_req   <= 1'b0;
            wait_ack_low <= 1'b0;
        end else if (o_word_req) begin
            if (i_word_ack) begin
                o_word_req   <= 1'b0;
                wait_ack_low <= 1'b1;
            end
        end else if (wait_ack_low) begin
            if (!i_word_ack) begin   // handshake closed
                wait_ack_low <= 1'b0;
                byte_cnt     <= 2'd0;
            end
        end else if (take_byte) begin
            byte_cnt <= byte_cnt + 2'd1;
            if (byte_cnt == 2'd3) begin
                o_word_req <= 1'b1;  // fourth byte in, offer the word
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (take_byte) begin
            word_q <= {word_q[23:0], i_rx_byte};
        end
    end

    assign o_word.data = word_q;

endmodule

`default_nettype wire

// ==== mips_debug.f ====
hw/debug_pkg.sv
hw/uart_word_rx.sv
hw/debug_ctrl.sv
hw/instr_mem.sv
hw/latch_dump.sv
hw/debug_top.sv
tb/tb_clock.sv
tb/debug_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module debug_tb -Mdir obj_dir -f mips_debug.f; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vdebug_tb)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx ">>> PASS" <<< "$sim_out"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1

// ==== tb/debug_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module debug_tb;

    localparam int CLK_NS       = 4;
    localparam int DRAIN_CYCLES = 3;    // debug_top default
    localparam int RUN_CYCLES   = 5;    // running cycles before the model reports program end
    localparam int BYTE_GAP     = 7;    // idle cycles after each received byte
    localparam int SNAP_BYTES   = 44;
    localparam int TEST_WORDS   = 26;
    localparam int TEST_DUMPS   = 5;
    // a byte in either direction costs at most 8 cycles, then doubled
    localparam int WATCHDOG_NS  = 2 * CLK_NS * 8 * (TEST_WORDS * 4 + TEST_DUMPS * SNAP_BYTES);

    localparam logic [191:0] PROG_A = {32'h2008_0005, 32'h2009_0003, 32'h0109_5020,
                                       32'hac0a_0000, 32'h8c0b_0000, 32'h0000_0000};
    localparam logic [191:0] PROG_B = {32'h2010_0007, 32'h2011_0002, 32'h0211_9022,
                                       32'h1000_ffff, 32'h0000_0000, 32'h3c01_1234};

    logic                      clk;
    logic                      reset;
    logic                      rx_valid;
    logic [7:0]                rx_byte;
    logic                      tx_req;
    logic [7:0]                tx_byte;
    logic                      tx_ack;
    logic                      program_end;
    logic                      run_end;     // raised by the pipeline model
    logic                      step_end;    // raised by the step test
    logic [7:0]                fetch_addr;
    debug_pkg::pipe_snapshot_t snapshot;
    logic [31:0]               fetch_instr;
    logic                      halt;
    logic                      stall;
    logic                      pc_reset;

    logic [7:0] tx_bytes[$];    // bytes taken by the transmitter model
    int         end_after;
    int         run_cnt;
    int         err_cnt = 0;
    int         check_cnt = 0;
    int         halt_low_cnt = 0;    // cycle counts, sampled at the rising edge
    int         stall_cnt = 0;
    int         stall_halt_low_cnt = 0;
    int         pc_reset_cnt = 0;

    assign program_end = run_end || step_end;

    tb_clock #(
        .PERIOD_NS    (CLK_NS),
        .RESET_CYCLES (4)
    ) u_clock (
        .o_clk   (clk),
        .o_reset (reset)
    );

    debug_top dut0 (
        .i_clk         (clk),
        .i_reset       (reset),
        .i_rx_valid    (rx_valid),
        .i_rx_byte     (rx_byte),
        .o_tx_req      (tx_req),
        .o_tx_byte     (tx_byte),
        .i_tx_ack      (tx_ack),
        .i_program_end (program_end),
        .i_fetch_addr  (fetch_addr),
        .i_snapshot    (snapshot),
        .o_fetch_instr (fetch_instr),
        .o_halt        (halt),
        .o_stall       (stall),
        .o_pc_reset    (pc_reset)
    );

    always @(posedge clk) begin
        if (!reset) begin
            if (!halt) halt_low_cnt++;
            if (stall) stall_cnt++;
            if (stall && !halt) stall_halt_low_cnt++;
            if (pc_reset) pc_reset_cnt++;
        end
    end

    // transmitter model, answers each request after 0 to 3 cycles
    initial begin
        tx_ack = 1'b0;
        forever begin
            @(negedge clk);
            if (tx_req && !tx_ack) begin
                repeat ($urandom_range(3, 0)) @(negedge clk);
                tx_bytes.push_back(tx_byte);
                tx_ack = 1'b1;
                while (tx_req) @(negedge clk);
                tx_ack = 1'b0;
            end
        end
    end

    // pipeline model, counts running cycles and reports the end marker
    initial begin
        run_end = 1'b0;
        run_cnt = 0;
        forever begin
            @(negedge clk);
            if (halt) begin
                run_cnt = 0;
                run_end = 1'b0;
            end else begin
                run_cnt++;
                if (end_after != 0 && run_cnt == end_after) run_end = 1'b1;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display(">>> FAIL");
        $finish;
    end

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_cnt++;
        assert (got === exp) else begin
            err_cnt++;
            $display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic send_word(input logic [31:0] word);
        int i;
        for (i = 3; i >= 0; i--) begin    // msb first
            @(negedge clk);
            rx_valid = 1'b1;
            rx_byte  = word[i*8 +: 8];
            @(negedge clk);
            rx_valid = 1'b0;
            repeat (BYTE_GAP - 1) @(negedge clk);
        end
    endtask

    task automatic randomize_snapshot();
        logic [351:0] bits;
        int k;
        for (k = 0; k < 11; k++) bits[32*k +: 32] = $urandom;
        snapshot     = bits;
        snapshot.pad = 2'b00;
    endtask

    task automatic collect_dump();
        logic [351:0] bits;
        int k;
        bits = snapshot;
        while (tx_bytes.size() < SNAP_BYTES) @(negedge clk);
        for (k = 0; k < SNAP_BYTES; k++) begin
            compare($sformatf("o_tx_byte[%0d]", k), 32'(tx_bytes[k]), 32'(bits[351 - 8*k -: 8]));
        end
        tx_bytes.delete();
    endtask

    task automatic wait_pc_reset(input int base);
        while (pc_reset_cnt == base) @(negedge clk);
    endtask

    task automatic check_program(input logic [191:0] prog);
        logic [31:0] exp;
        int k;
        for (k = 0; k < 7; k++) begin
            exp = (k == 6) ? 32'hffff_ffff : prog[191 - 32*k -: 32];
            @(negedge clk);
            fetch_addr = 8'(4 * k);
            @(negedge clk);    // registered read
            compare($sformatf("o_fetch_instr at 0x%h", fetch_addr), fetch_instr, exp);
        end
    endtask

    task automatic check_reset_and_ignored();
        int base_halt;
        compare("o_halt", 32'(halt), 1);
        compare("o_stall", 32'(stall), 0);
        compare("o_pc_reset", 32'(pc_reset), 0);
        compare("o_tx_req", 32'(tx_req), 0);
        base_halt = halt_low_cnt;
        send_word(debug_pkg::cmd_cont);
        send_word(debug_pkg::cmd_step);
        repeat (BYTE_GAP) @(negedge clk);
        compare("o_halt low cycles", halt_low_cnt - base_halt, 0);
        compare("o_tx_req transfers", tx_bytes.size(), 0);
    endtask

    task automatic charge(input logic [191:0] prog);
        int base_pc;
        int k;
        base_pc = pc_reset_cnt;
        send_word(debug_pkg::cmd_charge);
        for (k = 0; k < 6; k++) send_word(prog[191 - 32*k -: 32]);
        send_word(32'hffff_ffff);    // end marker goes into memory too
        compare("o_pc_reset pulse cycles", pc_reset_cnt - base_pc, 1);
        compare("o_halt", 32'(halt), 1);
        check_program(prog);
    endtask

    task automatic run_continuous();
        int base_halt;
        int base_stall;
        int base_sh;
        int base_pc;
        randomize_snapshot();
        base_halt = halt_low_cnt;
        base_stall = stall_cnt;
        base_sh = stall_halt_low_cnt;
        base_pc = pc_reset_cnt;
        end_after = RUN_CYCLES;
        send_word(debug_pkg::cmd_cont);
        collect_dump();
        compare("o_pc_reset pulse cycles before dump end", pc_reset_cnt - base_pc, 0);
        wait_pc_reset(base_pc);
        repeat (4) @(negedge clk);
        end_after = 0;
        compare("o_halt low cycles", halt_low_cnt - base_halt, RUN_CYCLES + DRAIN_CYCLES);
        compare("o_stall high cycles", stall_cnt - base_stall, DRAIN_CYCLES);
        compare("o_stall high with o_halt low", stall_halt_low_cnt - base_sh, DRAIN_CYCLES);
        compare("o_pc_reset pulse cycles", pc_reset_cnt - base_pc, 1);
        compare("o_halt", 32'(halt), 1);
    endtask

    task automatic run_steps();
        int base_halt;
        int base_stall;
        int base_pc;
        int k;
        base_pc = pc_reset_cnt;
        send_word(debug_pkg::cmd_step);
        for (k = 0; k < 3; k++) begin
            randomize_snapshot();
            step_end = (k == 2);    // last step runs into the end marker
            base_halt = halt_low_cnt;
            base_stall = stall_cnt;
            send_word(debug_pkg::cmd_next);
            collect_dump();
            compare($sformatf("o_halt low cycles, step %0d", k), halt_low_cnt - base_halt, 1);
            compare($sformatf("o_stall high cycles, step %0d", k), stall_cnt - base_stall,
                    (k == 2) ? 1 : 0);
            step_end = 1'b0;
        end
        base_halt = halt_low_cnt;
        send_word(32'h1234_5678);
        repeat (BYTE_GAP) @(negedge clk);
        compare("o_halt low cycles, unknown word", halt_low_cnt - base_halt, 0);
        compare("o_tx_req transfers, unknown word", tx_bytes.size(), 0);
        compare("o_pc_reset pulse cycles in step mode", pc_reset_cnt - base_pc, 0);
    endtask

    task automatic cancel_and_reload();
        int base_halt;
        int base_pc;
        base_halt = halt_low_cnt;
        base_pc = pc_reset_cnt;
        send_word(debug_pkg::cmd_cancel);
        compare("o_pc_reset pulse cycles, cancel", pc_reset_cnt - base_pc, 1);
        compare("o_halt low cycles, cancel", halt_low_cnt - base_halt, 0);
        compare("o_halt", 32'(halt), 1);
        charge(PROG_B);
        run_continuous();
    endtask

    initial begin
        void'($urandom(15));
        rx_valid   = 1'b0;
        rx_byte    = 8'h00;
        step_end   = 1'b0;
        end_after  = 0;
        fetch_addr = 8'h00;
        snapshot   = '0;
        @(negedge clk);
        while (reset !== 1'b0) @(posedge clk);
        @(negedge clk);

        check_reset_and_ignored();
        charge(PROG_A);
        run_continuous();
        run_steps();
        cancel_and_reload();

        $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 4
) (
    output logic o_clk,
    output logic o_reset
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    // reset drops on a falling edge, clear of the edge the DUT samples on
    initial begin
        o_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_reset = 1'b0;
    end

endmodule

`default_nettype wire
